//--- rtl/uart_mon_macros.svh
//==========================================================
// uart monitor size macros
// FIFO depth and baud divisor width for the tx path
//==========================================================

`ifndef UART_MON_MACROS_SVH
`define UART_MON_MACROS_SVH

// log2 of the tx FIFO depth, 16 entries by default
`define UART_MON_FIFO_AW 4

// baud divisor width, one bit time is divisor+1 clocks
`define UART_MON_DIV_W 16

`endif

//--- rtl/uart_mon_pkg.sv
//==========================================================
// uart monitor package
// request and config structs, ASCII control codes
//==========================================================

`default_nettype none

`include "uart_mon_macros.svh"

package uart_mon_pkg;

	// dump request from the monitor, strobes are one cycle
	typedef struct packed {
		logic        start;	// dump word as text
		logic        crlf;	// bare line end
		logic [31:0] word;
	} dump_req_t;

	// transmitter configuration
	typedef struct packed {
		logic                       en;
		logic [`UART_MON_DIV_W-1:0] div;
	} tx_cfg_t;

	localparam logic [7:0] CHAR_SPACE = 8'h20;
	localparam logic [7:0] CHAR_CR    = 8'h0d;
	localparam logic [7:0] CHAR_LF    = 8'h0a;

endpackage

`default_nettype wire

//--- rtl/uart_mon_char_encoder.sv
//==========================================================
// uart monitor character encoder
// turns a 32-bit word into "hh hh hh hh\r\n" one char
// per cycle, or sends a bare CR LF
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module uart_mon_char_encoder (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire uart_mon_pkg::dump_req_t req,
	input  wire                     fifo_full,
	output logic                    char_wr,
	output logic [7:0]              char_data,
	output logic                    dump_done
);

	logic        active;
	logic [5:0]  cnt;	// 12..0 for a word or 1..0 for crlf
	logic [31:0] word_q;
	logic [3:0]  nib;

	function automatic logic [7:0] hex_ascii(input logic [3:0] n);
		if (n < 4'd10)
			hex_ascii = 8'h30 + {4'h0, n};
		else
			hex_ascii = 8'h57 + {4'h0, n};	// lower case a-f
	endfunction

	// start wins over crlf and any new request restarts
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			cnt    <= 6'd0;
		end
		else if (req.start)
		begin
			active <= 1'b1;
			cnt    <= 6'd12;
		end
		else if (req.crlf)
		begin
			active <= 1'b1;
			cnt    <= 6'd1;
		end
		else if (char_wr)
		begin
			if (cnt == 6'd0)
				active <= 1'b0;
			else
				cnt <= cnt - 6'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req.start)
			word_q <= req.word;
	end

	// nibble for the current position with high digit first
	always_comb
	begin
		case (cnt)
			6'd12:   nib = word_q[31:28];
			6'd11:   nib = word_q[27:24];
			6'd9:    nib = word_q[23:20];
			6'd8:    nib = word_q[19:16];
			6'd6:    nib = word_q[15:12];
			6'd5:    nib = word_q[11:8];
			6'd3:    nib = word_q[7:4];
			6'd2:    nib = word_q[3:0];
			default: nib = 4'h0;
		endcase
	end

	always_comb
	begin
		case (cnt)
			6'd10, 6'd7, 6'd4: char_data = uart_mon_pkg::CHAR_SPACE;
			6'd1:              char_data = uart_mon_pkg::CHAR_CR;
			6'd0:              char_data = uart_mon_pkg::CHAR_LF;
			default:           char_data = hex_ascii(nib);
		endcase
	end

	assign char_wr   = active & ~fifo_full;	// stall on full while the count holds
	assign dump_done = char_wr & (cnt == 6'd0);

	// a stalled char stays pending until the FIFO has room
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		active && fifo_full && !req.start && !req.crlf |=> active && $stable(cnt));

endmodule

`default_nettype wire

//--- rtl/uart_tx_fifo.sv
//==========================================================
// uart tx byte FIFO
// circular buffer between encoder and serializer
//==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "uart_mon_macros.svh"

module uart_tx_fifo #(
	parameter int AW = `UART_MON_FIFO_AW
) (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        wr,
	input  wire  [7:0] wdata,
	output logic       full,
	input  wire        rd,
	output logic [7:0] rdata,
	output logic       empty
);

	localparam int DEPTH = 1 << AW;

	logic [7:0]  mem [DEPTH];
	logic [AW:0] wr_ptr;	// msb is the wrap bit
	logic [AW:0] rd_ptr;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr && !full)
			mem[wr_ptr[AW-1:0]] <= wdata;
	end

	// same index, different lap means full
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);
	assign rdata = mem[rd_ptr[AW-1:0]];	// head, valid when not empty

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr |-> !full);

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rd |-> !empty);

endmodule

`default_nettype wire

//--- rtl/uart_tx_serializer.sv
//==========================================================
// uart tx serializer
// sends 8N1 frames LSB first, bit time is divisor+1 clocks
//==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "uart_mon_macros.svh"

module uart_tx_serializer (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire uart_mon_pkg::tx_cfg_t cfg,
	input  wire                     fifo_empty,
	input  wire  [7:0]              fifo_data,
	output logic                    pop,
	output logic                    tx,
	output logic                    busy
);

	logic [`UART_MON_DIV_W-1:0] baud_cnt;
	logic [3:0]                 bit_cnt;	// bits left after the current one
	logic [8:0]                 shreg;		// data then stop
	logic                       bit_end;

	// enable only checked while idle, so a frame always completes
	assign pop     = !busy && cfg.en && !fifo_empty;
	assign bit_end = busy && (baud_cnt == '0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy     <= 1'b0;
			tx       <= 1'b1;
			baud_cnt <= '0;
			bit_cnt  <= 4'd0;
		end
		else if (pop)
		begin
			busy     <= 1'b1;
			tx       <= 1'b0;	// start bit
			baud_cnt <= cfg.div;
			bit_cnt  <= 4'd9;
		end
		else if (busy)
		begin
			if (!bit_end)
				baud_cnt <= baud_cnt - 1'b1;
			else if (bit_cnt == 4'd0)
				busy <= 1'b0;	// end of stop bit
			else
			begin
				tx       <= shreg[0];
				bit_cnt  <= bit_cnt - 4'd1;
				baud_cnt <= cfg.div;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
			shreg <= {1'b1, fifo_data};
		else if (bit_end && bit_cnt != 4'd0)
			shreg <= {1'b1, shreg[8:1]};
	end

	// register block must hold a real divisor before enable
	a_div_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> cfg.div != '0);

endmodule

`default_nettype wire

//--- rtl/uart_mon_cfg_regs.sv
//==========================================================
// uart monitor config registers
// addr 0 baud divisor, addr 1 tx enable
//==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "uart_mon_macros.svh"

module uart_mon_cfg_regs (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      reg_we,
	input  wire                      reg_addr,
	input  wire  [15:0]              reg_wdata,
	output logic [15:0]              reg_rdata,
	output uart_mon_pkg::tx_cfg_t    cfg
);

	logic [`UART_MON_DIV_W-1:0] div_q;
	logic                       en_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_q <= '0;
			en_q  <= 1'b0;
		end
		else if (reg_we)
		begin
			if (reg_addr)
				en_q <= reg_wdata[0];
			else
				div_q <= reg_wdata[`UART_MON_DIV_W-1:0];
		end
	end

	assign cfg.en  = en_q;
	assign cfg.div = div_q;

	// readback
	assign reg_rdata = reg_addr ? {15'd0, en_q} : 16'(div_q);

endmodule

`default_nettype wire

//--- rtl/uart_mon_top.sv
//==========================================================
// uart monitor transmit top
// encoder -> byte FIFO -> 8N1 serializer, plus config regs
//==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "uart_mon_macros.svh"

module uart_mon_top (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire uart_mon_pkg::dump_req_t req,
	input  wire                     reg_we,
	input  wire                     reg_addr,
	input  wire  [15:0]             reg_wdata,
	output logic [15:0]             reg_rdata,
	output logic                    dump_done,
	output logic                    busy,
	output logic                    tx
);

	logic                  char_wr;
	logic [7:0]            char_data;
	logic                  fifo_full;
	logic                  fifo_empty;
	logic [7:0]            fifo_rdata;
	logic                  fifo_pop;
	uart_mon_pkg::tx_cfg_t tx_cfg;

	uart_mon_char_encoder i_encoder (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.fifo_full (fifo_full),
		.char_wr   (char_wr),
		.char_data (char_data),
		.dump_done (dump_done)
	);

	uart_tx_fifo #(
		.AW (`UART_MON_FIFO_AW)
	) i_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (char_wr),
		.wdata (char_data),
		.full  (fifo_full),
		.rd    (fifo_pop),
		.rdata (fifo_rdata),
		.empty (fifo_empty)
	);

	uart_tx_serializer i_serializer (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (tx_cfg),
		.fifo_empty (fifo_empty),
		.fifo_data  (fifo_rdata),
		.pop        (fifo_pop),
		.tx         (tx),
		.busy       (busy)
	);

	uart_mon_cfg_regs i_cfg (
		.clk       (clk),
		.rst_n     (rst_n),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.cfg       (tx_cfg)
	);

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
//==========================================================
// testbench clock and reset
// free running clock, reset held low for a few cycles
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int HALF_PERIOD = 4,
	parameter int RST_CYCLES  = 8
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release just after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/tb_uart_mon.sv
//==========================================================
// uart monitor tx testbench
// directed tests, tx decoded back to bytes at mid bit
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module tb_uart_mon;

	logic                    clk;
	logic                    rst_n;
	uart_mon_pkg::dump_req_t req;
	logic                    reg_we;
	logic                    reg_addr;
	logic [15:0]             reg_wdata;
	logic [15:0]             reg_rdata;
	logic                    dump_done;
	logic                    busy;
	logic                    tx;

	int         err_cnt;
	int         done_cnt;
	int         bit_div;	// divisor the decoder assumes
	logic [7:0] rx_q[$];
	logic [7:0] exp_q[$];

	tb_clkgen #(
		.HALF_PERIOD (4),
		.RST_CYCLES  (8)
	) i_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	uart_mon_top i_uart_mon_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.dump_done (dump_done),
		.busy      (busy),
		.tx        (tx)
	);

	always @(negedge clk)
	begin
		if (rst_n && dump_done)
			done_cnt = done_cnt + 1;
	end

	task automatic write_reg(input logic addr, input logic [15:0] data);
		@(posedge clk);
		#1;
		reg_we    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(posedge clk);
		#1;
		reg_we = 1'b0;
	endtask

	task automatic read_reg(input logic addr, output logic [15:0] data);
		@(posedge clk);
		#1;
		reg_addr = addr;
		@(negedge clk);
		data = reg_rdata;	// combinational readback
	endtask

	task automatic pulse_req(input logic start, input logic crlf, input logic [31:0] word);
		@(posedge clk);
		#1;
		req.start = start;
		req.crlf  = crlf;
		req.word  = word;
		@(posedge clk);
		#1;
		req.start = 1'b0;
		req.crlf  = 1'b0;
	endtask

	task automatic wait_done(input string name, input int target);
		int t;
		t = 0;
		while (done_cnt < target && t < 20000)
		begin
			@(negedge clk);
			t++;
		end
		if (done_cnt < target)
		begin
			$display("ERROR: %s timed out waiting for dump_done", name);
			err_cnt++;
		end
	endtask

	task automatic wait_idle(input string name);
		int   t;
		int   k;
		logic extra;
		t = 0;
		while ((busy || tx !== 1'b1) && t < 5000)
		begin
			@(negedge clk);
			t++;
		end
		if (busy || tx !== 1'b1)
		begin
			$display("ERROR: %s serializer never went idle", name);
			err_cnt++;
		end
		// a leftover char would start a new frame within a cycle
		extra = 1'b0;
		for (k = 0; k < 4; k++)
		begin
			@(negedge clk);
			if (busy !== 1'b0 || tx !== 1'b1)
				extra = 1'b1;
		end
		if (extra)
		begin
			$display("ERROR: %s extra character sent after the line", name);
			err_cnt++;
		end
	endtask

	// one 8N1 frame sampled on falling clock edges
	task automatic recv_byte(input string name, output logic [7:0] b, output logic ok);
		int t;
		int i;
		t = 0;
		b = 8'h00;
		while (tx !== 1'b0 && t < 40 * (bit_div + 1) + 100)
		begin
			@(negedge clk);
			t++;
		end
		ok = (tx === 1'b0);
		if (!ok)
		begin
			$display("ERROR: %s no start bit on tx before timeout", name);
			err_cnt++;
		end
		else
		begin
			repeat ((bit_div + 1) / 2) @(negedge clk);	// middle of start bit
			if (tx !== 1'b0)
			begin
				$display("ERROR: %s start bit ended early", name);
				err_cnt++;
			end
			if (busy !== 1'b1)
			begin
				$display("FAILED %s: busy in frame expected %0d, got %0d", name, 1, busy);
				err_cnt++;
			end
			for (i = 0; i < 8; i++)
			begin
				repeat (bit_div + 1) @(negedge clk);
				b[i] = tx;	// lsb first
			end
			repeat (bit_div + 1) @(negedge clk);
			if (tx !== 1'b1)
			begin
				$display("ERROR: %s stop bit was low", name);
				err_cnt++;
			end
		end
	endtask

	task automatic recv_line(input string name, input int n);
		logic [7:0] b;
		logic       ok;
		int         k;
		rx_q.delete();
		for (k = 0; k < n; k++)
		begin
			recv_byte(name, b, ok);
			if (!ok)
				break;
			rx_q.push_back(b);
		end
	endtask

	// "hh hh hh hh" then CR LF
	function automatic void add_word_text(input logic [31:0] word);
		string hex_digits;
		int    p;
		hex_digits = "0123456789abcdef";
		for (p = 0; p < 4; p++)
		begin
			exp_q.push_back(hex_digits[int'(word[31 - 8 * p -: 4])]);
			exp_q.push_back(hex_digits[int'(word[27 - 8 * p -: 4])]);
			if (p < 3)
				exp_q.push_back(8'h20);
		end
		exp_q.push_back(8'h0d);
		exp_q.push_back(8'h0a);
	endfunction

	task automatic compare_line(input string name);
		int k;
		if (rx_q.size() != exp_q.size())
		begin
			$display("FAILED %s: expected %0d bytes, got %0d", name, exp_q.size(), rx_q.size());
			err_cnt++;
		end
		for (k = 0; k < exp_q.size() && k < rx_q.size(); k++)
		begin
			if (rx_q[k] !== exp_q[k])
			begin
				$display("FAILED %s: byte %0d expected %02h, got %02h",
					name, k, exp_q[k], rx_q[k]);
				err_cnt++;
			end
		end
	endtask

	task automatic test_reg_readback;
		logic [15:0] rd;
		write_reg(1'b0, 16'd3);
		write_reg(1'b1, 16'd1);
		bit_div = 3;
		read_reg(1'b0, rd);
		if (rd !== 16'd3)
		begin
			$display("FAILED reg_readback: expected %0d, got %0d", 3, rd);
			err_cnt++;
		end
		read_reg(1'b1, rd);
		if (rd !== 16'd1)
		begin
			$display("FAILED reg_readback: expected %0d, got %0d", 1, rd);
			err_cnt++;
		end
	endtask

	task automatic dump_and_check(input string name, input logic [31:0] word);
		exp_q.delete();
		add_word_text(word);
		done_cnt = 0;
		fork
			begin
				pulse_req(1'b1, 1'b0, word);
				wait_done(name, 1);
			end
			recv_line(name, 13);
		join
		compare_line(name);
		if (done_cnt != 1)
		begin
			$display("FAILED %s: expected %0d dump_done pulses, got %0d", name, 1, done_cnt);
			err_cnt++;
		end
		wait_idle(name);
	endtask

	task automatic test_crlf;
		exp_q.delete();
		exp_q.push_back(8'h0d);
		exp_q.push_back(8'h0a);
		done_cnt = 0;
		fork
			begin
				pulse_req(1'b0, 1'b1, 32'h0);
				wait_done("crlf", 1);
			end
			recv_line("crlf", 2);
		join
		compare_line("crlf");
		wait_idle("crlf");
	endtask

	// 65 chars through a 16 deep FIFO make the encoder stall
	task automatic test_random_words;
		logic [31:0] words [5];
		int          j;
		exp_q.delete();
		for (j = 0; j < 5; j++)
		begin
			words[j] = $urandom;
			add_word_text(words[j]);
		end
		done_cnt = 0;
		fork
			begin
				for (j = 0; j < 5; j++)
				begin
					pulse_req(1'b1, 1'b0, words[j]);
					wait_done("random_words", j + 1);
				end
			end
			recv_line("random_words", 65);
		join
		compare_line("random_words");
		if (done_cnt != 5)
		begin
			$display("FAILED random_words: expected %0d dump_done pulses, got %0d", 5, done_cnt);
			err_cnt++;
		end
		wait_idle("random_words");
	endtask

	task automatic test_enable_gating;
		logic [31:0] word;
		int          t;
		int          low_cnt;
		word = $urandom;
		write_reg(1'b1, 16'd0);
		exp_q.delete();
		add_word_text(word);
		done_cnt = 0;
		pulse_req(1'b1, 1'b0, word);
		wait_done("enable_gating", 1);
		low_cnt = 0;
		for (t = 0; t < 200; t++)
		begin
			@(negedge clk);
			if (tx !== 1'b1)
				low_cnt++;
		end
		if (low_cnt != 0)
		begin
			$display("FAILED enable_gating: expected %0d low tx cycles, got %0d", 0, low_cnt);
			err_cnt++;
		end
		fork
			write_reg(1'b1, 16'd1);
			recv_line("enable_gating", 13);
		join
		compare_line("enable_gating");
		wait_idle("enable_gating");
	endtask

	task automatic test_divisor_change;
		write_reg(1'b0, 16'd7);
		bit_div = 7;	// bit time now 8 clocks
		dump_and_check("divisor_change", $urandom);
	endtask

	initial
	begin
		int t;
		req       = '0;
		reg_we    = 1'b0;
		reg_addr  = 1'b0;
		reg_wdata = 16'h0000;
		err_cnt   = 0;
		done_cnt  = 0;
		bit_div   = 3;
		void'($urandom(32'h7fdf725f));
		t = 0;
		while (rst_n !== 1'b1 && t < 100)
		begin
			@(posedge clk);
			t++;
		end
		if (rst_n !== 1'b1)
		begin
			$display("ERROR: reset was never released");
			err_cnt++;
		end
		test_reg_readback();
		dump_and_check("word_dump", 32'hdeadbeef);
		test_crlf();
		test_random_words();
		test_enable_gating();
		test_divisor_change();
		$display("errors: %0d", err_cnt);
		if (err_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/uart_mon_pkg.sv
rtl/uart_mon_char_encoder.sv
rtl/uart_tx_fifo.sv
rtl/uart_tx_serializer.sv
rtl/uart_mon_cfg_regs.sv
rtl/uart_mon_top.sv
tb/tb_clkgen.sv
tb/tb_uart_mon.sv

//--- Makefile
# Verilator build and run of the uart monitor tx testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_mon
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
